// ==== Bender.yml ====
package:
  name: adv_timer

sources:
  - include_dirs:
      - .
    files:
      - adv_timer_pkg.sv
      - adv_timer_regs.sv
      - timer_counter.sv
      - timer_compare.sv
      - timer_event_detect.sv
      - adv_timer_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_adv_timer.sv

// ==== adv_timer.f ====
+incdir+.
adv_timer_pkg.sv
adv_timer_regs.sv
timer_counter.sv
timer_compare.sv
timer_event_detect.sv
adv_timer_top.sv
tb_adv_timer.sv

// ==== adv_timer_pkg.sv ====
/*
 * Shared types of the timer block.
 * Compare op codes 5 to 7 are legal register values and leave the output unchanged.
 */
`include "adv_timer_settings.svh"

package adv_timer_pkg;

  typedef logic [`ADV_TIMER_CNT_W-1:0]   cnt_t;
  typedef logic [`ADV_TIMER_PRESC_W-1:0] presc_t;

  // Selects one bit of the concatenated channel vector of all timers
  typedef logic [$clog2(`ADV_TIMER_NUM_TIMERS*`ADV_TIMER_NUM_CH)-1:0] ch_sel_t;

  typedef enum logic [2:0] {
    OP_SET       = 3'd0,
    OP_CLEAR     = 3'd1,
    OP_TOGGLE    = 3'd2,
    OP_SET_CLEAR = 3'd3,
    OP_CLEAR_SET = 3'd4
  } cmp_op_e;

  // One-cycle command pulses
  typedef struct packed {
    logic start;
    logic stop;
    logic rst;
  } timer_cmd_t;

  typedef struct packed {
    presc_t presc;
    logic   saw;
    cnt_t   th_lo;
    cnt_t   th_hi;
  } timer_cfg_t;

  typedef struct packed {
    cnt_t    th;
    cmp_op_e op;
  } ch_cfg_t;

  typedef struct packed {
    logic tick;
    logic period_end;
    cnt_t value;
  } timer_state_t;

  typedef struct packed {
    ch_sel_t [`ADV_TIMER_NUM_EVENTS-1:0] sel;
    logic    [`ADV_TIMER_NUM_EVENTS-1:0] en;
  } event_cfg_t;

endpackage

// ==== adv_timer_regs.sv ====
/*
 * APB slave with the timer and event registers. PREADY is tied high.
 * Unmapped or unaligned addresses read 0, ignore writes and raise PSLVERR.
 * CMD writes become one-cycle pulses in the cycle after the access phase.
 */
`timescale 1ns/100ps
`include "adv_timer_settings.svh"

module adv_timer_regs (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic [`ADV_TIMER_ADDR_W-1:0]  paddr_i,
  input  logic [31:0]                   pwdata_i,
  input  logic                          pwrite_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  output logic [31:0]                   prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  input  adv_timer_pkg::timer_state_t   state_i    [`ADV_TIMER_NUM_TIMERS],
  output adv_timer_pkg::timer_cmd_t     cmd_o      [`ADV_TIMER_NUM_TIMERS],
  output adv_timer_pkg::timer_cfg_t     cfg_o      [`ADV_TIMER_NUM_TIMERS],
  output adv_timer_pkg::ch_cfg_t        ch_cfg_o   [`ADV_TIMER_NUM_TIMERS][`ADV_TIMER_NUM_CH],
  output adv_timer_pkg::event_cfg_t     event_cfg_o
);

  import adv_timer_pkg::*;

  localparam int unsigned BankLsb = $clog2(`ADV_TIMER_TIMER_STRIDE);
  localparam int unsigned BankW   = $clog2(`ADV_TIMER_NUM_TIMERS);
  localparam int unsigned ChW     = $clog2(`ADV_TIMER_NUM_CH);
  localparam int unsigned ChLast  = `ADV_TIMER_REG_CH0 + 4 * (`ADV_TIMER_NUM_CH - 1);

  logic [BankW-1:0]   bank;
  logic [BankLsb-1:0] offset;
  logic [ChW-1:0]     ch_idx;
  logic               in_timers;
  logic               is_ch;
  logic               mapped;
  logic               access;
  logic               wr_en;
  logic [31:0]        rdata;

  ////////////////////
  // Address decode
  ////////////////////
  assign bank      = paddr_i[BankLsb +: BankW];
  assign offset    = paddr_i[BankLsb-1:0];
  assign in_timers = paddr_i < `ADV_TIMER_NUM_TIMERS * `ADV_TIMER_TIMER_STRIDE;
  assign is_ch     = (offset >= `ADV_TIMER_REG_CH0) && (offset <= ChLast) &&
                     (offset[1:0] == 2'b00);
  assign ch_idx    = ChW'((offset - BankLsb'(`ADV_TIMER_REG_CH0)) >> 2);

  assign access    = psel_i & penable_i;
  assign wr_en     = access & pwrite_i & mapped;
  assign pslverr_o = access & ~mapped;
  assign pready_o  = 1'b1;
  assign prdata_o  = rdata;

  ////////////////////
  // Readback
  ////////////////////
  always_comb begin
    rdata  = '0;
    mapped = 1'b0;
    if (in_timers) begin
      mapped = 1'b1;
      case (offset)
        // CMD is write-only
        `ADV_TIMER_REG_CMD: rdata = '0;
        `ADV_TIMER_REG_CFG: rdata = 32'({cfg_o[bank].saw, cfg_o[bank].presc});
        `ADV_TIMER_REG_TH:  rdata = {cfg_o[bank].th_hi, cfg_o[bank].th_lo};
        `ADV_TIMER_REG_CNT: rdata = 32'(state_i[bank].value);
        default: begin
          mapped = is_ch;
          if (is_ch) begin
            rdata = 32'({ch_cfg_o[bank][ch_idx].op, ch_cfg_o[bank][ch_idx].th});
          end
        end
      endcase
    end else if (paddr_i == `ADV_TIMER_REG_EVENT) begin
      mapped = 1'b1;
      for (int e = 0; e < `ADV_TIMER_NUM_EVENTS; e++) begin
        rdata[4*e +: $bits(ch_sel_t)] = event_cfg_o.sel[e];
      end
      rdata[16 +: `ADV_TIMER_NUM_EVENTS] = event_cfg_o.en;
    end
  end

  ////////////////////
  // Register writes
  ////////////////////
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      for (int t = 0; t < `ADV_TIMER_NUM_TIMERS; t++) begin
        cmd_o[t] <= '0;
        cfg_o[t] <= '0;
        for (int c = 0; c < `ADV_TIMER_NUM_CH; c++) begin
          ch_cfg_o[t][c] <= '0;
        end
      end
      event_cfg_o <= '0;
    end else begin
      // Command bits only live for one cycle
      for (int t = 0; t < `ADV_TIMER_NUM_TIMERS; t++) begin
        cmd_o[t] <= '0;
      end
      if (wr_en && in_timers) begin
        case (offset)
          `ADV_TIMER_REG_CMD: begin
            cmd_o[bank].start <= pwdata_i[0];
            cmd_o[bank].stop  <= pwdata_i[1];
            cmd_o[bank].rst   <= pwdata_i[2];
          end
          `ADV_TIMER_REG_CFG: begin
            cfg_o[bank].presc <= pwdata_i[`ADV_TIMER_PRESC_W-1:0];
            cfg_o[bank].saw   <= pwdata_i[8];
          end
          `ADV_TIMER_REG_TH: begin
            cfg_o[bank].th_lo <= pwdata_i[`ADV_TIMER_CNT_W-1:0];
            cfg_o[bank].th_hi <= pwdata_i[16 +: `ADV_TIMER_CNT_W];
          end
          default: begin
            if (is_ch) begin
              ch_cfg_o[bank][ch_idx].th <= pwdata_i[`ADV_TIMER_CNT_W-1:0];
              ch_cfg_o[bank][ch_idx].op <= cmp_op_e'(pwdata_i[18:16]);
            end
          end
        endcase
      end else if (wr_en) begin
        for (int e = 0; e < `ADV_TIMER_NUM_EVENTS; e++) begin
          event_cfg_o.sel[e] <= pwdata_i[4*e +: $bits(ch_sel_t)];
        end
        event_cfg_o.en <= pwdata_i[16 +: `ADV_TIMER_NUM_EVENTS];
      end
    end
  end

  // A setup phase is always followed by its access phase
  a_setup_then_access: assert property (
    @(posedge HCLK) disable iff (!HRESETn) psel_i && !penable_i |=> psel_i && penable_i
  );

endmodule

// ==== adv_timer_settings.svh ====
/*
 * Widths, counts and the APB register map of the two-timer PWM block.
 * Timer bank offsets are relative to the bank base, banks are ADV_TIMER_TIMER_STRIDE apart.
 */
`ifndef ADV_TIMER_SETTINGS_SVH
`define ADV_TIMER_SETTINGS_SVH

`define ADV_TIMER_CNT_W        16
`define ADV_TIMER_PRESC_W      8
`define ADV_TIMER_NUM_TIMERS   2
`define ADV_TIMER_NUM_CH       4
`define ADV_TIMER_NUM_EVENTS   4
`define ADV_TIMER_ADDR_W       12

// Offsets inside one timer bank, channels follow CH0 every 4 bytes
`define ADV_TIMER_REG_CMD      'h00
`define ADV_TIMER_REG_CFG      'h04
`define ADV_TIMER_REG_TH       'h08
`define ADV_TIMER_REG_CH0      'h0C
`define ADV_TIMER_REG_CNT      'h1C

`define ADV_TIMER_TIMER_STRIDE 'h40
`define ADV_TIMER_REG_EVENT    'h80

`endif

// ==== adv_timer_top.sv ====
/*
 * Two-timer PWM block with an APB register interface, all on HCLK.
 * Event selects index {ch_1_o, ch_0_o}, so timer 0 owns selects 0 to 3.
 */
`timescale 1ns/100ps
`include "adv_timer_settings.svh"

module adv_timer_top (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic [`ADV_TIMER_ADDR_W-1:0]     paddr_i,
  input  logic [31:0]                      pwdata_i,
  input  logic                             pwrite_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  output logic [31:0]                      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  output logic [`ADV_TIMER_NUM_CH-1:0]     ch_0_o,
  output logic [`ADV_TIMER_NUM_CH-1:0]     ch_1_o,
  output logic [`ADV_TIMER_NUM_EVENTS-1:0] events_o
);

  import adv_timer_pkg::*;

  timer_cmd_t   cmd       [`ADV_TIMER_NUM_TIMERS];
  timer_cfg_t   cfg       [`ADV_TIMER_NUM_TIMERS];
  ch_cfg_t      ch_cfg    [`ADV_TIMER_NUM_TIMERS][`ADV_TIMER_NUM_CH];
  timer_state_t state     [`ADV_TIMER_NUM_TIMERS];
  event_cfg_t   event_cfg;

  logic [`ADV_TIMER_NUM_CH-1:0]                      pwm [`ADV_TIMER_NUM_TIMERS];
  logic [`ADV_TIMER_NUM_TIMERS*`ADV_TIMER_NUM_CH-1:0] ch_all;

  adv_timer_regs i_regs (
    .HCLK        ( HCLK      ),
    .HRESETn     ( HRESETn   ),
    .paddr_i     ( paddr_i   ),
    .pwdata_i    ( pwdata_i  ),
    .pwrite_i    ( pwrite_i  ),
    .psel_i      ( psel_i    ),
    .penable_i   ( penable_i ),
    .prdata_o    ( prdata_o  ),
    .pready_o    ( pready_o  ),
    .pslverr_o   ( pslverr_o ),
    .state_i     ( state     ),
    .cmd_o       ( cmd       ),
    .cfg_o       ( cfg       ),
    .ch_cfg_o    ( ch_cfg    ),
    .event_cfg_o ( event_cfg )
  );

  for (genvar t = 0; t < `ADV_TIMER_NUM_TIMERS; t++) begin : gen_timer
    timer_counter i_counter (
      .HCLK    ( HCLK     ),
      .HRESETn ( HRESETn  ),
      .cmd_i   ( cmd[t]   ),
      .cfg_i   ( cfg[t]   ),
      .state_o ( state[t] )
    );

    timer_compare i_compare (
      .HCLK     ( HCLK      ),
      .HRESETn  ( HRESETn   ),
      .state_i  ( state[t]  ),
      .ch_cfg_i ( ch_cfg[t] ),
      .pwm_o    ( pwm[t]    )
    );
  end

  assign ch_0_o = pwm[0];
  assign ch_1_o = pwm[1];
  assign ch_all = {pwm[1], pwm[0]};

  timer_event_detect i_event_detect (
    .HCLK     ( HCLK      ),
    .HRESETn  ( HRESETn   ),
    .ch_i     ( ch_all    ),
    .cfg_i    ( event_cfg ),
    .events_o ( events_o  )
  );

endmodule

// ==== tb_adv_timer.sv ====
/*
 * Self-checking testbench of the two-timer PWM block.
 * A cycle model follows counters, compare outputs and events from the written registers.
 * Stimulus comes from a Galois LFSR with a fixed seed. Thresholds keep th_lo below th_hi.
 */
`timescale 1ns/100ps
`include "adv_timer_settings.svh"

module tb_adv_timer;

  typedef logic [`ADV_TIMER_ADDR_W-1:0] addr_t;

  logic        HCLK;
  logic        HRESETn;
  addr_t       paddr;
  logic [31:0] pwdata;
  logic        pwrite;
  logic        psel;
  logic        penable;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [`ADV_TIMER_NUM_CH-1:0]     ch_0;
  logic [`ADV_TIMER_NUM_CH-1:0]     ch_1;
  logic [`ADV_TIMER_NUM_EVENTS-1:0] events;

  logic [31:0] lfsr_q;
  int          errors;
  int          checks;

  // Register words as last written over APB
  logic [31:0] cfg_w    [`ADV_TIMER_NUM_TIMERS];
  logic [31:0] th_w     [`ADV_TIMER_NUM_TIMERS];
  logic [31:0] ch_w     [`ADV_TIMER_NUM_TIMERS][`ADV_TIMER_NUM_CH];
  logic [31:0] ev_w;
  logic [2:0]  cmd_pend [`ADV_TIMER_NUM_TIMERS];

  // Cycle model state
  logic        m_run       [`ADV_TIMER_NUM_TIMERS];
  logic [7:0]  m_presc_cnt [`ADV_TIMER_NUM_TIMERS];
  logic        m_down      [`ADV_TIMER_NUM_TIMERS];
  logic        m_tick      [`ADV_TIMER_NUM_TIMERS];
  logic        m_pend      [`ADV_TIMER_NUM_TIMERS];
  logic [15:0] m_value     [`ADV_TIMER_NUM_TIMERS];
  logic [7:0]  m_pwm;
  logic [1:0]  m_smp       [`ADV_TIMER_NUM_EVENTS];

  initial HCLK = 1'b0;
  always #50 HCLK = ~HCLK;

  adv_timer_top i_adv_timer_top (
    .HCLK      ( HCLK    ),
    .HRESETn   ( HRESETn ),
    .paddr_i   ( paddr   ),
    .pwdata_i  ( pwdata  ),
    .pwrite_i  ( pwrite  ),
    .psel_i    ( psel    ),
    .penable_i ( penable ),
    .prdata_o  ( prdata  ),
    .pready_o  ( pready  ),
    .pslverr_o ( pslverr ),
    .ch_0_o    ( ch_0    ),
    .ch_1_o    ( ch_1    ),
    .events_o  ( events  )
  );

  ////////////////////
  // Random numbers
  ////////////////////
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step for every bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  ////////////////////
  // Register map
  ////////////////////
  function automatic addr_t reg_addr(int t, int off);
    return addr_t'(t * `ADV_TIMER_TIMER_STRIDE + off);
  endfunction

  function automatic logic is_mapped(addr_t addr);
    int off;
    off = addr % `ADV_TIMER_TIMER_STRIDE;
    if (addr == `ADV_TIMER_REG_EVENT) return 1'b1;
    if (addr >= `ADV_TIMER_NUM_TIMERS * `ADV_TIMER_TIMER_STRIDE) return 1'b0;
    return off == `ADV_TIMER_REG_CMD || off == `ADV_TIMER_REG_CFG ||
           off == `ADV_TIMER_REG_TH || off == `ADV_TIMER_REG_CNT ||
           (off >= `ADV_TIMER_REG_CH0 && off <= 'h18 && off % 4 == 0);
  endfunction

  function automatic logic [31:0] expect_read(addr_t addr);
    int t;
    int off;
    t   = addr / `ADV_TIMER_TIMER_STRIDE;
    off = addr % `ADV_TIMER_TIMER_STRIDE;
    if (addr == `ADV_TIMER_REG_EVENT) return ev_w & 32'h000F_7777;
    if (!is_mapped(addr)) return '0;
    case (off)
      `ADV_TIMER_REG_CFG: return cfg_w[t] & 32'h0000_01FF;
      `ADV_TIMER_REG_TH:  return th_w[t];
      `ADV_TIMER_REG_CNT: return 32'(m_value[t]);
      `ADV_TIMER_REG_CMD: return '0;
      default:            return ch_w[t][(off - `ADV_TIMER_REG_CH0) / 4] & 32'h0007_FFFF;
    endcase
  endfunction

  function automatic void shadow_write(addr_t addr, logic [31:0] data);
    int t;
    int off;
    t   = addr / `ADV_TIMER_TIMER_STRIDE;
    off = addr % `ADV_TIMER_TIMER_STRIDE;
    if (!is_mapped(addr)) return;
    if (addr == `ADV_TIMER_REG_EVENT) begin
      ev_w = data;
      return;
    end
    case (off)
      `ADV_TIMER_REG_CMD: cmd_pend[t] = data[2:0];
      `ADV_TIMER_REG_CFG: cfg_w[t] = data;
      `ADV_TIMER_REG_TH:  th_w[t] = data;
      `ADV_TIMER_REG_CNT: ;
      default:            ch_w[t][(off - `ADV_TIMER_REG_CH0) / 4] = data;
    endcase
  endfunction

  ////////////////////
  // Model
  ////////////////////
  task automatic model_reset();
    for (int t = 0; t < `ADV_TIMER_NUM_TIMERS; t++) begin
      cfg_w[t] = '0;
      th_w[t] = '0;
      cmd_pend[t] = '0;
      m_run[t] = 1'b0;
      m_presc_cnt[t] = '0;
      m_down[t] = 1'b0;
      m_tick[t] = 1'b0;
      m_pend[t] = 1'b0;
      m_value[t] = '0;
      for (int c = 0; c < `ADV_TIMER_NUM_CH; c++) begin
        ch_w[t][c] = '0;
      end
    end
    ev_w = '0;
    m_pwm = '0;
    for (int e = 0; e < `ADV_TIMER_NUM_EVENTS; e++) begin
      m_smp[e] = '0;
    end
  endtask

  // Output level after one tick, from the op table of the compare stage
  function automatic logic next_pwm(logic cur, logic [31:0] chw, logic [15:0] value,
                                    logic pend);
    if (value == chw[15:0]) begin
      case (chw[18:16])
        3'd0, 3'd3: return 1'b1;
        3'd1, 3'd4: return 1'b0;
        3'd2:       return ~cur;
        default:    return cur;
      endcase
    end
    if (pend && chw[18:16] == 3'd3) return 1'b0;
    if (pend && chw[18:16] == 3'd4) return 1'b1;
    return cur;
  endfunction

  // Advances the model by one HCLK edge, using the state from before the edge
  task automatic model_step();
    logic [7:0]  ch_now;
    logic [15:0] lo;
    logic [15:0] hi;
    ch_now = m_pwm;
    for (int e = 0; e < `ADV_TIMER_NUM_EVENTS; e++) begin
      if (ev_w[16 + e]) m_smp[e] = {m_smp[e][0], ch_now[ev_w[4*e +: 3]]};
    end
    for (int t = 0; t < `ADV_TIMER_NUM_TIMERS; t++) begin
      lo = th_w[t][15:0];
      hi = th_w[t][31:16];
      if (m_tick[t]) begin
        for (int c = 0; c < `ADV_TIMER_NUM_CH; c++) begin
          m_pwm[4*t + c] = next_pwm(m_pwm[4*t + c], ch_w[t][c], m_value[t], m_pend[t]);
        end
      end
      m_tick[t] = 1'b0;
      m_pend[t] = 1'b0;
      if (cmd_pend[t][2]) begin
        m_value[t] = lo;
        m_presc_cnt[t] = '0;
        m_down[t] = 1'b0;
      end else if (m_run[t] && m_presc_cnt[t] != cfg_w[t][7:0]) begin
        m_presc_cnt[t]++;
      end else if (m_run[t]) begin
        m_presc_cnt[t] = '0;
        m_tick[t] = 1'b1;
        if (cfg_w[t][8]) begin
          m_pend[t] = m_value[t] == hi;
          m_value[t] = m_pend[t] ? lo : m_value[t] + 16'd1;
        end else if (!m_down[t]) begin
          m_value[t]++;
          m_down[t] = m_value[t] == hi;
        end else begin
          m_value[t]--;
          m_pend[t] = m_value[t] == lo;
          m_down[t] = !m_pend[t];
        end
      end
      if (cmd_pend[t][0]) m_run[t] = 1'b1;
      else if (cmd_pend[t][1]) m_run[t] = 1'b0;
      cmd_pend[t] = '0;
    end
  endtask

  task automatic compare_outputs();
    logic [3:0] exp_ev;
    for (int e = 0; e < `ADV_TIMER_NUM_EVENTS; e++) begin
      exp_ev[e] = ev_w[16 + e] & m_smp[e][0] & ~m_smp[e][1];
    end
    checks += 3;
    if (ch_0 !== m_pwm[3:0]) begin
      errors++;
      $display("** Error: ch_0_o = %h, expected %h at %0t", ch_0, m_pwm[3:0], $time);
    end
    if (ch_1 !== m_pwm[7:4]) begin
      errors++;
      $display("** Error: ch_1_o = %h, expected %h at %0t", ch_1, m_pwm[7:4], $time);
    end
    if (events !== exp_ev) begin
      errors++;
      $display("** Error: events_o = %h, expected %h at %0t", events, exp_ev, $time);
    end
  endtask

  // Outputs settle well before mid-cycle
  always @(posedge HCLK) begin
    if (HRESETn) begin
      model_step();
      #40;
      compare_outputs();
    end
  end

  ////////////////////
  // APB transfers
  ////////////////////
  task automatic idle_cycles(int n);
    repeat (n) @(posedge HCLK);
    #10;
  endtask

  task automatic access_phase(output logic [31:0] rdata, output logic [31:0] exp,
                              output logic err);
    int waits;
    @(posedge HCLK);
    #10;
    penable = 1'b1;
    #30;
    waits = 0;
    while (!pready && waits < 16) begin
      @(posedge HCLK);
      #40;
      waits++;
    end
    if (!pready) begin
      errors++;
      $display("APB transfer to %h saw no PREADY within 16 cycles", paddr);
    end
    rdata = prdata;
    exp   = expect_read(paddr);
    err   = pslverr;
    @(posedge HCLK);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_err(addr_t addr, logic err);
    checks++;
    if (err !== !is_mapped(addr)) begin
      errors++;
      $display("** Error: pslverr_o = %h, expected %h at address %h", err, !is_mapped(addr),
               addr);
    end
  endtask

  task automatic apb_write(addr_t addr, logic [31:0] data);
    logic [31:0] rdata;
    logic [31:0] exp;
    logic        err;
    paddr  = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel   = 1'b1;
    access_phase(rdata, exp, err);
    check_err(addr, err);
    shadow_write(addr, data);
  endtask

  task automatic apb_read(addr_t addr);
    logic [31:0] rdata;
    logic [31:0] exp;
    logic        err;
    paddr  = addr;
    pwrite = 1'b0;
    psel   = 1'b1;
    access_phase(rdata, exp, err);
    check_err(addr, err);
    checks++;
    if (rdata !== exp) begin
      errors++;
      $display("** Error: prdata_o = %h, expected %h at address %h", rdata, exp, addr);
    end
  endtask

  ////////////////////
  // Test sequences
  ////////////////////
  task automatic check_all_regs();
    for (int t = 0; t < `ADV_TIMER_NUM_TIMERS; t++) begin
      apb_read(reg_addr(t, `ADV_TIMER_REG_CMD));
      apb_read(reg_addr(t, `ADV_TIMER_REG_CFG));
      apb_read(reg_addr(t, `ADV_TIMER_REG_TH));
      for (int c = 0; c < `ADV_TIMER_NUM_CH; c++) begin
        apb_read(reg_addr(t, `ADV_TIMER_REG_CH0 + 4 * c));
      end
      apb_read(reg_addr(t, `ADV_TIMER_REG_CNT));
    end
    apb_read(`ADV_TIMER_REG_EVENT);
  endtask

  task automatic check_registers();
    for (int t = 0; t < `ADV_TIMER_NUM_TIMERS; t++) begin
      apb_write(reg_addr(t, `ADV_TIMER_REG_CFG), rand_bits(32));
      apb_write(reg_addr(t, `ADV_TIMER_REG_TH), rand_bits(32));
      for (int c = 0; c < `ADV_TIMER_NUM_CH; c++) begin
        apb_write(reg_addr(t, `ADV_TIMER_REG_CH0 + 4 * c), rand_bits(32));
      end
    end
    apb_write(`ADV_TIMER_REG_EVENT, rand_bits(32));
    check_all_regs();
  endtask

  task automatic check_unmapped();
    addr_t addr;
    for (int i = 0; i < 16; i++) begin
      case (rand_bits(2))
        0:       addr = reg_addr(rand_bits(1), 'h20 + 4 * rand_bits(3));
        1:       addr = reg_addr(rand_bits(1), 4 * rand_bits(3) + 1 + rand_bits(1));
        default: addr = addr_t'(12'h084 + rand_bits(11));
      endcase
      if (rand_bits(1)) apb_write(addr, rand_bits(32));
      else apb_read(addr);
    end
    check_all_regs();
  endtask

  // Reads CNT while running and once more after stop
  task automatic check_counting(logic saw);
    int          t;
    logic [7:0]  presc;
    logic [15:0] lo;
    int          span;
    t     = rand_bits(1);
    presc = 8'(saw ? rand_bits(2) : rand_bits(1));
    lo    = 16'(rand_bits(12));
    span  = saw ? 1 + rand_bits(4) : 2 + rand_bits(3);
    apb_write(reg_addr(t, `ADV_TIMER_REG_CFG), {23'd0, saw, presc});
    apb_write(reg_addr(t, `ADV_TIMER_REG_TH), {lo + 16'(span), lo});
    apb_write(reg_addr(t, `ADV_TIMER_REG_CMD), 32'h5);
    for (int r = 0; r < 4; r++) begin
      idle_cycles(10 + rand_bits(5));
      apb_read(reg_addr(t, `ADV_TIMER_REG_CNT));
    end
    apb_write(reg_addr(t, `ADV_TIMER_REG_CMD), 32'h2);
    idle_cycles(2 + rand_bits(3));
    apb_read(reg_addr(t, `ADV_TIMER_REG_CNT));
  endtask

  task automatic check_compare_events();
    logic [15:0] lo;
    logic [15:0] th;
    int          span;
    for (int t = 0; t < `ADV_TIMER_NUM_TIMERS; t++) begin
      lo   = 16'(rand_bits(10));
      span = 3 + rand_bits(4);
      apb_write(reg_addr(t, `ADV_TIMER_REG_CFG), rand_bits(10) & 32'h103);
      apb_write(reg_addr(t, `ADV_TIMER_REG_TH), {lo + 16'(span), lo});
      for (int c = 0; c < `ADV_TIMER_NUM_CH; c++) begin
        th = lo + 16'(rand_bits(5) % (span + 1));
        apb_write(reg_addr(t, `ADV_TIMER_REG_CH0 + 4 * c), {13'd0, 3'(rand_bits(3)), th});
      end
    end
    apb_write(`ADV_TIMER_REG_EVENT, rand_bits(32));
    apb_write(reg_addr(0, `ADV_TIMER_REG_CMD), 32'h5);
    apb_write(reg_addr(1, `ADV_TIMER_REG_CMD), 32'h5);
    idle_cycles(300);
    // New selects and enables while both timers keep running
    for (int r = 0; r < 3; r++) begin
      apb_write(`ADV_TIMER_REG_EVENT, rand_bits(32));
      idle_cycles(150);
    end
    apb_write(reg_addr(0, `ADV_TIMER_REG_CMD), 32'h2);
    apb_write(reg_addr(1, `ADV_TIMER_REG_CMD), 32'h2);
    idle_cycles(20);
  endtask

  initial begin
    lfsr_q  = 32'h5709553a;
    errors  = 0;
    checks  = 0;
    HRESETn = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pwrite  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    model_reset();
    repeat (4) @(posedge HCLK);
    #10;
    HRESETn = 1'b1;

    check_registers();
    check_unmapped();
    check_counting(1'b1);
    check_counting(1'b0);
    check_compare_events();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== timer_compare.sv ====
/*
 * Compare channels of one timer. Outputs change one edge after a tick.
 * A match action takes priority over the period-end action of the same tick.
 */
`timescale 1ns/100ps
`include "adv_timer_settings.svh"

module timer_compare (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  adv_timer_pkg::timer_state_t   state_i,
  input  adv_timer_pkg::ch_cfg_t        ch_cfg_i [`ADV_TIMER_NUM_CH],
  output logic [`ADV_TIMER_NUM_CH-1:0]  pwm_o
);

  import adv_timer_pkg::*;

  function automatic logic apply_op(logic cur, cmp_op_e op, logic match, logic pend);
    logic res;
    res = cur;
    if (match) begin
      case (op)
        OP_SET, OP_SET_CLEAR:   res = 1'b1;
        OP_CLEAR, OP_CLEAR_SET: res = 1'b0;
        OP_TOGGLE:              res = ~cur;
        default:                res = cur;
      endcase
    end else if (pend) begin
      // Only the two-phase ops act at the end of a period
      case (op)
        OP_SET_CLEAR: res = 1'b0;
        OP_CLEAR_SET: res = 1'b1;
        default:      res = cur;
      endcase
    end
    return res;
  endfunction

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      pwm_o <= '0;
    end else if (state_i.tick) begin
      for (int c = 0; c < `ADV_TIMER_NUM_CH; c++) begin
        pwm_o[c] <= apply_op(pwm_o[c], ch_cfg_i[c].op,
                             state_i.value == ch_cfg_i[c].th,
                             state_i.period_end);
      end
    end
  end

endmodule

// ==== timer_counter.sv ====
/*
 * Prescaler and counter of one timer. Requires th_lo < th_hi while running.
 * In up-down mode the value turns at th_hi and th_lo, each visited once per turn.
 */
`timescale 1ns/100ps

module timer_counter (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  adv_timer_pkg::timer_cmd_t   cmd_i,
  input  adv_timer_pkg::timer_cfg_t   cfg_i,
  output adv_timer_pkg::timer_state_t state_o
);

  import adv_timer_pkg::*;

  typedef enum logic {
    DIR_UP,
    DIR_DOWN
  } dir_e;

  logic   running_q;
  presc_t presc_cnt_q;
  dir_e   dir_q;
  logic   step;
  cnt_t   value_nxt;
  logic   wrap_nxt;
  dir_e   dir_nxt;

  assign step = running_q && (presc_cnt_q == cfg_i.presc);

  ////////////////////
  // Next count value
  ////////////////////
  always_comb begin
    value_nxt = state_o.value + 1'b1;
    wrap_nxt  = 1'b0;
    dir_nxt   = dir_q;
    if (cfg_i.saw) begin
      if (state_o.value == cfg_i.th_hi) begin
        value_nxt = cfg_i.th_lo;
        wrap_nxt  = 1'b1;
      end
    end else if (dir_q == DIR_UP) begin
      if (value_nxt == cfg_i.th_hi) dir_nxt = DIR_DOWN;
    end else begin
      value_nxt = state_o.value - 1'b1;
      if (value_nxt == cfg_i.th_lo) begin
        wrap_nxt = 1'b1;
        dir_nxt  = DIR_UP;
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      running_q   <= 1'b0;
      presc_cnt_q <= '0;
      dir_q       <= DIR_UP;
      state_o     <= '0;
    end else begin
      if (cmd_i.start) running_q <= 1'b1;
      else if (cmd_i.stop) running_q <= 1'b0;

      state_o.tick       <= 1'b0;
      state_o.period_end <= 1'b0;
      if (cmd_i.rst) begin
        state_o.value <= cfg_i.th_lo;
        presc_cnt_q   <= '0;
        dir_q         <= DIR_UP;
      end else if (step) begin
        presc_cnt_q        <= '0;
        state_o.value      <= value_nxt;
        dir_q              <= dir_nxt;
        state_o.tick       <= 1'b1;
        state_o.period_end <= wrap_nxt;
      end else if (running_q) begin
        presc_cnt_q <= presc_cnt_q + 1'b1;
      end
    end
  end

  a_tick_in_range: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    state_o.tick |-> (state_o.value >= cfg_i.th_lo) && (state_o.value <= cfg_i.th_hi)
  );

endmodule

// ==== timer_event_detect.sv ====
/*
 * Rising-edge events on selected channel bits.
 * A pulse is high in the cycle after the first stage captures the new high level.
 * A disabled event freezes its samples, so re-enabling can fire on a stale edge.
 */
`timescale 1ns/100ps
`include "adv_timer_settings.svh"

module timer_event_detect (
  input  logic                                             HCLK,
  input  logic                                             HRESETn,
  input  logic [`ADV_TIMER_NUM_TIMERS*`ADV_TIMER_NUM_CH-1:0] ch_i,
  input  adv_timer_pkg::event_cfg_t                        cfg_i,
  output logic [`ADV_TIMER_NUM_EVENTS-1:0]                 events_o
);

  // Bit 0 is the first sampling stage, bit 1 the second
  logic [1:0] smp_q [`ADV_TIMER_NUM_EVENTS];

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      for (int e = 0; e < `ADV_TIMER_NUM_EVENTS; e++) begin
        smp_q[e] <= '0;
      end
    end else begin
      for (int e = 0; e < `ADV_TIMER_NUM_EVENTS; e++) begin
        if (cfg_i.en[e]) smp_q[e] <= {smp_q[e][0], ch_i[cfg_i.sel[e]]};
      end
    end
  end

  always_comb begin
    for (int e = 0; e < `ADV_TIMER_NUM_EVENTS; e++) begin
      events_o[e] = cfg_i.en[e] & smp_q[e][0] & ~smp_q[e][1];
    end
  end

  for (genvar e = 0; e < `ADV_TIMER_NUM_EVENTS; e++) begin : gen_chk
    a_single_pulse: assert property (
      @(posedge HCLK) disable iff (!HRESETn) events_o[e] |=> !events_o[e]
    );
  end

endmodule
